/* tests/matrix_input.txt */
// op (0 read, 1 write, 2 GPIO input read, ff end), address, size (0 byte, 1 half, 2 word)
// write data on its byte lanes, expected read data
// RAM word write with a read in the very next cycle
1 00000010 2 a5a55a5a 00000000
0 00000010 2 00000000 a5a55a5a
// Two words back to back, then both read
1 00000020 2 11223344 00000000
1 00000024 2 deadbeef 00000000
0 00000020 2 00000000 11223344
0 00000024 2 00000000 deadbeef
// Byte and halfword lanes merge into the word at 0x20
1 00000021 0 0000ab00 00000000
1 00000022 1 cafe0000 00000000
0 00000020 2 00000000 cafeab44
1 00000020 0 00000077 00000000
0 00000020 2 00000000 cafeab77
// Reset memory and RAM at equal offsets
1 1fc00020 2 0badf00d 00000000
0 00000020 2 00000000 cafeab77
0 1fc00020 2 00000000 0badf00d
1 00000040 2 55aa00ff 00000000
1 1fc00040 2 12345678 00000000
0 00000040 2 00000000 55aa00ff
0 1fc00040 2 00000000 12345678
// GPIO strobes, index 9 is past the last output word
1 1f800008 2 13572468 00000000
1 1f800014 2 2468ace0 00000000
1 1f800024 2 0f0f0f0f 00000000
2 1f80000c 2 00000000 00000000
2 1f800000 2 00000000 00000000
2 1f800020 2 00000000 00000000
// Unmapped read, then RAM again
0 10000000 2 00000000 00000000
0 00000010 2 00000000 a5a55a5a
ff 00000000 0 00000000 00000000

/* files.f */
hdl/mfp_pkg.sv
hdl/ahb_decoder.sv
hdl/ahb_lite_1xn.sv
hdl/ahb_lite_bram.sv
hdl/mfp_ahb_gpio.sv
hdl/mfp_ahb_lite_matrix.sv
tests/mfp_matrix_chk.sv
tests/tb_mfp_matrix.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mfp_matrix -f files.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_mfp_matrix > sim.log 2>&1
cat sim.log

grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/tb_mfp_matrix.sv */
`timescale 1ns/100ps

module tb_mfp_matrix;
    import mfp_pkg::*;

    localparam int ram_addr_width   = 12;
    localparam int reset_addr_width = 10;
    localparam int gpior_count      = 8;
    localparam int gpiow_count      = 8;

    localparam int clk_period  = 100;
    localparam int ready_limit = 16;
    localparam int max_ops     = 64;

    // Columns of one operation in the stimulus file
    localparam int col_op   = 0;
    localparam int col_addr = 1;
    localparam int col_size = 2;
    localparam int col_data = 3;
    localparam int col_exp  = 4;
    localparam int cols     = 5;

    localparam logic [31:0] op_read      = 32'h0;
    localparam logic [31:0] op_write     = 32'h1;
    localparam logic [31:0] op_gpio_read = 32'h2;
    localparam logic [31:0] op_end       = 32'hff;

    logic                                    HCLK = 1'b0;
    logic                                    rst_n;
    ahb_req_t                                cpu_req;
    logic [hdata_width-1:0]                  cpu_hwdata;
    ahb_rsp_t                                cpu_rsp;
    logic [gpior_count-1:0][hdata_width-1:0] gpio_rd;
    logic [hdata_width-1:0]                  gpio_wd;
    logic [gpiow_count-1:0]                  gpio_we;

    logic [31:0] vectors [cols*max_ops];
    logic [31:0] gpio_words [gpior_count];
    logic [31:0] held_wd;
    int          op_count;
    int          check_count;
    int          error_count;
    logic        timed_out;

    mfp_ahb_lite_matrix #(
        .ram_addr_width   ( ram_addr_width   ),
        .reset_addr_width ( reset_addr_width ),
        .gpior_count      ( gpior_count      ),
        .gpiow_count      ( gpiow_count      )
    ) UUT (
        .HCLK       ( HCLK       ),
        .rst_n      ( rst_n      ),
        .cpu_req    ( cpu_req    ),
        .cpu_hwdata ( cpu_hwdata ),
        .cpu_rsp    ( cpu_rsp    ),
        .gpio_rd    ( gpio_rd    ),
        .gpio_wd    ( gpio_wd    ),
        .gpio_we    ( gpio_we    )
    );

    bind mfp_ahb_lite_matrix mfp_matrix_chk #(
        .gpiow_count ( gpiow_count )
    ) matrix_chk (
        .HCLK      ( HCLK                     ),
        .rst_n     ( rst_n                    ),
        .cpu_req   ( cpu_req                  ),
        .cpu_rsp   ( cpu_rsp                  ),
        .gpio_hsel ( hsel[mfp_pkg::port_gpio] ),
        .hready    ( hready                   ),
        .gpio_we   ( gpio_we                  )
    );

    always #(clk_period / 2) HCLK = ~HCLK;

    function automatic logic [31:0] op_field(input int k, input int col);
        return vectors[k*cols + col];
    endfunction

    // GPIO block decoded from address bits 28:22 at 0x1f800000
    function automatic logic is_gpio(input logic [31:0] addr);
        return addr[28:22] == 7'h7e;
    endfunction

    function automatic logic [31:0] gpio_word_at(input logic [19:0] idx);
        if (int'(idx) < gpior_count) begin
            return gpio_words[idx];
        end
        return 32'h0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic drive_address(input int k);
        cpu_req.haddr  = op_field(k, col_addr);
        cpu_req.htrans = htrans_nonseq;
        cpu_req.hsize  = hsize_t'(op_field(k, col_size) & 32'h7);
        cpu_req.hwrite = (op_field(k, col_op) == op_write);
    endtask

    // Samples a quarter period after the falling edge, inputs held while low
    task automatic wait_ready(input int step);
        int waited;

        waited = 0;
        #(clk_period / 4);
        while (cpu_rsp.hreadyout !== 1'b1 && waited < ready_limit) begin
            @(negedge HCLK);
            #(clk_period / 4);
            waited++;
        end
        if (cpu_rsp.hreadyout !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout: HREADY stayed low for %0d cycles at step %0d", waited, step);
        end
    endtask

    task automatic check_data_phase(input int k);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [19:0] idx;
        logic [31:0] exp_we;
        int          errors_before;

        op            = op_field(k, col_op);
        addr          = op_field(k, col_addr);
        data          = op_field(k, col_data);
        idx           = addr[21:2];
        errors_before = error_count;

        // No strobe past the last output word
        exp_we = 32'h0;
        if (op == op_write && is_gpio(addr) && int'(idx) < gpiow_count) begin
            exp_we = 32'h1 << idx;
        end

        // Output word follows a strobed write and holds until the next one
        if (exp_we != 32'h0) begin
            held_wd = data;
        end

        if (op == op_read) begin
            compare_value("cpu_rsp.hrdata", cpu_rsp.hrdata, op_field(k, col_exp));
        end else if (op == op_gpio_read) begin
            compare_value("cpu_rsp.hrdata", cpu_rsp.hrdata, gpio_word_at(idx));
        end
        compare_value("cpu_rsp.hresp", 32'(cpu_rsp.hresp), 32'h0);
        compare_value("gpio_we", 32'(gpio_we), exp_we);
        compare_value("gpio_wd", gpio_wd, held_wd);

        $display("op %0d %s at %08h: %0d mismatches", k,
                 (op == op_write) ? "write" : "read", addr, error_count - errors_before);
    endtask

    initial begin
        rst_n       = 1'b0;
        cpu_req     = '0;
        cpu_hwdata  = '0;
        held_wd     = 32'h0;
        op_count    = 0;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;

        void'($urandom(32'he3ac));
        for (int i = 0; i < gpior_count; i++) begin
            gpio_words[i] = $urandom;
            gpio_rd[i]    = gpio_words[i];
        end

        for (int i = 0; i < cols*max_ops; i++) begin
            vectors[i] = op_end;
        end
        $readmemh("tests/matrix_input.txt", vectors);
        while (op_count < max_ops && op_field(op_count, col_op) != op_end) begin
            op_count++;
        end

        repeat (2) @(posedge HCLK);
        @(negedge HCLK);
        rst_n = 1'b1;

        // Address phase of op i overlaps the data phase of op i-1
        for (int i = 0; i <= op_count; i++) begin
            if (!timed_out) begin
                @(negedge HCLK);
                if (i < op_count) begin
                    drive_address(i);
                end else begin
                    cpu_req.htrans = htrans_idle;
                end
                if (i > 0 && op_field(i - 1, col_op) == op_write) begin
                    cpu_hwdata = op_field(i - 1, col_data);
                end else begin
                    cpu_hwdata = '0;
                end
                wait_ready(i);
                if (!timed_out && i > 0) begin
                    check_data_phase(i - 1);
                end
            end
        end

        $display("%0d operations, %0d checks, %0d errors", op_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/mfp_matrix_chk.sv */
`timescale 1ns/100ps

module mfp_matrix_chk #(
    parameter int gpiow_count = 8
) (
    input logic                    HCLK,
    input logic                    rst_n,
    input mfp_pkg::ahb_req_t       cpu_req,
    input mfp_pkg::ahb_rsp_t       cpu_rsp,
    input logic                    gpio_hsel,
    input logic                    hready,
    input logic [gpiow_count-1:0]  gpio_we
);
    import mfp_pkg::*;

    logic gpio_wr_accept;

    // Address phase of a GPIO write taken on this edge
    assign gpio_wr_accept = gpio_hsel && hready && cpu_req.hwrite &&
                            ((cpu_req.htrans == htrans_nonseq) ||
                             (cpu_req.htrans == htrans_seq));

    hresp_okay: assert property (@(posedge HCLK) disable iff (!rst_n)
        cpu_rsp.hresp == 1'b0)
        else $error("hresp went high on the master port");

    we_onehot: assert property (@(posedge HCLK) disable iff (!rst_n)
        $onehot0(gpio_we))
        else $error("gpio_we has more than one bit set: %b", gpio_we);

    we_after_write: assert property (@(posedge HCLK) disable iff (!rst_n)
        !$past(gpio_wr_accept) |-> (gpio_we == '0))
        else $error("gpio_we set without a GPIO write in the cycle before");

endmodule

/* hdl/mfp_ahb_lite_matrix.sv */
`timescale 1ns/100ps

module mfp_ahb_lite_matrix #(
    parameter int ram_addr_width   = 12,
    parameter int reset_addr_width = 10,
    parameter int gpior_count      = 8,
    parameter int gpiow_count      = 8
) (
    input  logic                                              HCLK,
    input  logic                                              rst_n,

    input  mfp_pkg::ahb_req_t                                 cpu_req,
    input  logic [mfp_pkg::hdata_width-1:0]                   cpu_hwdata,
    output mfp_pkg::ahb_rsp_t                                 cpu_rsp,

    input  logic [gpior_count-1:0][mfp_pkg::hdata_width-1:0]  gpio_rd,
    output logic [mfp_pkg::hdata_width-1:0]                   gpio_wd,
    output logic [gpiow_count-1:0]                            gpio_we
);
    import mfp_pkg::*;

    // Shared slave bus
    ahb_req_t                         req;
    logic [hdata_width-1:0]           hwdata;
    logic [hport_count-1:0]           hsel;
    logic                             hready;
    ahb_rsp_t [hport_count-1:0]       rsp;

    // Decoder
    haddr_t                           d_haddr;
    logic [hport_count-1:0]           d_hsel;

    ahb_lite_1xn ahb_lite_1xn (
        .HCLK     ( HCLK       ),
        .rst_n    ( rst_n      ),
        .s_req    ( cpu_req    ),
        .s_hwdata ( cpu_hwdata ),
        .s_rsp    ( cpu_rsp    ),
        .m_req    ( req        ),
        .m_hwdata ( hwdata     ),
        .m_hsel   ( hsel       ),
        .m_hready ( hready     ),
        .m_rsp    ( rsp        ),
        .d_haddr  ( d_haddr    ),
        .d_hsel   ( d_hsel     )
    );

    ahb_decoder ahb_decoder (
        .haddr ( d_haddr ),
        .hsel  ( d_hsel  )
    );

    ahb_lite_bram #(
        .addr_width ( reset_addr_width )
    ) reset_ram (
        .HCLK   ( HCLK             ),
        .rst_n  ( rst_n            ),
        .req    ( req              ),
        .hwdata ( hwdata           ),
        .hsel   ( hsel[port_reset] ),
        .hready ( hready           ),
        .rsp    ( rsp[port_reset]  )
    );

    ahb_lite_bram #(
        .addr_width ( ram_addr_width )
    ) ram (
        .HCLK   ( HCLK           ),
        .rst_n  ( rst_n          ),
        .req    ( req            ),
        .hwdata ( hwdata         ),
        .hsel   ( hsel[port_ram] ),
        .hready ( hready         ),
        .rsp    ( rsp[port_ram]  )
    );

    mfp_ahb_gpio #(
        .gpior_count ( gpior_count ),
        .gpiow_count ( gpiow_count )
    ) gpio (
        .HCLK    ( HCLK            ),
        .rst_n   ( rst_n           ),
        .req     ( req             ),
        .hwdata  ( hwdata          ),
        .hsel    ( hsel[port_gpio] ),
        .hready  ( hready          ),
        .rsp     ( rsp[port_gpio]  ),
        .gpio_rd ( gpio_rd         ),
        .gpio_wd ( gpio_wd         ),
        .gpio_we ( gpio_we         )
    );

endmodule

/* hdl/mfp_ahb_gpio.sv */
`timescale 1ns/100ps

module mfp_ahb_gpio #(
    parameter int gpior_count = 8,
    parameter int gpiow_count = 8
) (
    input  logic                                              HCLK,
    input  logic                                              rst_n,
    input  mfp_pkg::ahb_req_t                                 req,
    input  logic [mfp_pkg::hdata_width-1:0]                   hwdata,
    input  logic                                              hsel,
    input  logic                                              hready,
    output mfp_pkg::ahb_rsp_t                                 rsp,
    input  logic [gpior_count-1:0][mfp_pkg::hdata_width-1:0]  gpio_rd,
    output logic [mfp_pkg::hdata_width-1:0]                   gpio_wd,
    output logic [gpiow_count-1:0]                            gpio_we
);
    import mfp_pkg::*;

    logic                   active;
    logic [19:0]            idx;
    logic [hdata_width-1:0] rd_word;
    logic                   wr_fire;

    logic                   wr_q;
    logic [19:0]            idx_q;
    logic [hdata_width-1:0] rdata_q;
    logic [hdata_width-1:0] wd_q;

    assign active = hsel && ((req.htrans == htrans_nonseq) || (req.htrans == htrans_seq));

    // Word index, byte offset dropped
    assign idx = req.haddr.region.offset[21:2];

    // Out of range reads return zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < gpior_count; i++) begin
            if (idx == 20'(i)) begin
                rd_word = gpio_rd[i];
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else if (hready) begin
            wr_q <= active && req.hwrite && (idx < gpiow_count);
        end
    end

    always_ff @(posedge HCLK) begin
        if (hready) begin
            idx_q   <= idx;
            rdata_q <= rd_word;
        end
    end

    assign wr_fire = wr_q && hready;

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wd_q <= '0;
        end else if (wr_fire) begin
            wd_q <= hwdata;
        end
    end

    // Strobe and data visible during the write data phase
    always_comb begin
        gpio_we = '0;
        for (int i = 0; i < gpiow_count; i++) begin
            gpio_we[i] = wr_fire && (idx_q == 20'(i));
        end
    end

    assign gpio_wd = wr_fire ? hwdata : wd_q;

    assign rsp.hrdata    = rdata_q;
    assign rsp.hreadyout = 1'b1;
    assign rsp.hresp     = 1'b0;

endmodule

/* hdl/ahb_lite_bram.sv */
`timescale 1ns/100ps

module ahb_lite_bram #(
    parameter int addr_width = 10
) (
    input  logic                            HCLK,
    input  logic                            rst_n,
    input  mfp_pkg::ahb_req_t               req,
    input  logic [mfp_pkg::hdata_width-1:0] hwdata,
    input  logic                            hsel,
    input  logic                            hready,
    output mfp_pkg::ahb_rsp_t               rsp
);
    import mfp_pkg::*;

    localparam int lanes = hdata_width / 8;

    logic [hdata_width-1:0] mem [2**addr_width];

    logic                   active;
    logic [addr_width-1:0]  rd_idx;
    logic [lanes-1:0]       be;
    logic                   fwd;

    logic                   wr_q;
    logic [addr_width-1:0]  idx_q;
    logic [lanes-1:0]       be_q;
    logic [hdata_width-1:0] rdata_q;

    assign active = hsel && ((req.htrans == htrans_nonseq) || (req.htrans == htrans_seq));
    assign rd_idx = req.haddr.mem.offset[addr_width+1:2];

    // Byte lanes from size and low address bits
    always_comb begin
        case (req.hsize)
            hsize_byte: be = 4'b0001 << req.haddr.mem.offset[1:0];
            hsize_half: be = req.haddr.mem.offset[1] ? 4'b1100 : 4'b0011;
            default:    be = 4'b1111;
        endcase
    end

    // Address phase capture
    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else if (hready) begin
            wr_q <= active && req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (hready) begin
            idx_q <= rd_idx;
            be_q  <= be;
        end
    end

    // Data phase write
    always_ff @(posedge HCLK) begin
        if (wr_q && hready) begin
            for (int i = 0; i < lanes; i++) begin
                if (be_q[i]) begin
                    mem[idx_q][i*8 +: 8] <= hwdata[i*8 +: 8];
                end
            end
        end
    end

    // Read of a word written on this same edge takes the new bytes
    assign fwd = wr_q && (rd_idx == idx_q);

    always_ff @(posedge HCLK) begin
        if (hready) begin
            for (int i = 0; i < lanes; i++) begin
                if (fwd && be_q[i]) begin
                    rdata_q[i*8 +: 8] <= hwdata[i*8 +: 8];
                end else begin
                    rdata_q[i*8 +: 8] <= mem[rd_idx][i*8 +: 8];
                end
            end
        end
    end

    assign rsp.hrdata    = rdata_q;
    assign rsp.hreadyout = 1'b1;
    assign rsp.hresp     = 1'b0;

endmodule

/* hdl/ahb_lite_1xn.sv */
`timescale 1ns/100ps

module ahb_lite_1xn (
    input  logic                                            HCLK,
    input  logic                                            rst_n,

    // Master side
    input  mfp_pkg::ahb_req_t                               s_req,
    input  logic [mfp_pkg::hdata_width-1:0]                 s_hwdata,
    output mfp_pkg::ahb_rsp_t                               s_rsp,

    // Slave side
    output mfp_pkg::ahb_req_t                               m_req,
    output logic [mfp_pkg::hdata_width-1:0]                 m_hwdata,
    output logic [mfp_pkg::hport_count-1:0]                 m_hsel,
    output logic                                            m_hready,
    input  mfp_pkg::ahb_rsp_t [mfp_pkg::hport_count-1:0]    m_rsp,

    // Address decoder
    output mfp_pkg::haddr_t                                 d_haddr,
    input  logic [mfp_pkg::hport_count-1:0]                 d_hsel
);
    import mfp_pkg::*;

    logic                   active;
    logic [hport_count-1:0] sel_q;
    ahb_rsp_t               rsp_mux;

    // Request and write data go to every slave
    assign m_req    = s_req;
    assign m_hwdata = s_hwdata;

    assign d_haddr = s_req.haddr;
    assign m_hsel  = d_hsel;

    assign active = (s_req.htrans == htrans_nonseq) || (s_req.htrans == htrans_seq);

    // Select of the transfer now in its data phase
    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (m_hready) begin
            sel_q <= active ? d_hsel : '0;
        end
    end

    // Idle or unmapped data phase completes with OKAY and zero data
    always_comb begin
        rsp_mux.hrdata    = '0;
        rsp_mux.hreadyout = 1'b1;
        rsp_mux.hresp     = 1'b0;
        for (int i = 0; i < hport_count; i++) begin
            if (sel_q[i]) begin
                rsp_mux = m_rsp[i];
            end
        end
    end

    assign s_rsp    = rsp_mux;
    assign m_hready = rsp_mux.hreadyout;

endmodule

/* hdl/ahb_decoder.sv */
`timescale 1ns/100ps

module ahb_decoder (
    input  mfp_pkg::haddr_t                    haddr,
    output logic [mfp_pkg::hport_count-1:0]    hsel
);
    import mfp_pkg::*;

    logic reset_hit;
    logic ram_hit;
    logic gpio_hit;

    // Reset vector memory, 0x1fc00000 - 0x1fffffff
    assign reset_hit = (haddr.region.match == reset_addr_match);

    // Main RAM, 0x00000000 - 0x03ffffff
    assign ram_hit = (haddr.mem.match == ram_addr_match);

    // GPIO block, 0x1f800000 - 0x1fbfffff
    assign gpio_hit = (haddr.region.match == gpio_addr_match);

    always_comb begin
        hsel             = '0;
        hsel[port_reset] = reset_hit;
        hsel[port_ram]   = ram_hit;
        hsel[port_gpio]  = gpio_hit;
    end

endmodule

/* hdl/mfp_pkg.sv */
package mfp_pkg;

    localparam int haddr_width = 32;
    localparam int hdata_width = 32;
    localparam int hport_count = 3;

    // Slave port indices
    localparam int port_reset = 0;
    localparam int port_ram   = 1;
    localparam int port_gpio  = 2;

    // Compared with physical address bits 28:22
    localparam logic [6:0] reset_addr_match = 7'h7f;
    localparam logic [6:0] gpio_addr_match  = 7'h7e;

    // Compared with bits 28:26, 64 MB window
    localparam logic [2:0] ram_addr_match = 3'h0;

    // 4 MB regions
    typedef struct packed {
        logic [2:0]              seg;
        logic [6:0]              match;
        logic [haddr_width-11:0] offset;
    } haddr_region_t;

    // 64 MB memory window
    typedef struct packed {
        logic [2:0]             seg;
        logic [2:0]             match;
        logic [haddr_width-7:0] offset;
    } haddr_mem_t;

    typedef union packed {
        haddr_region_t region;
        haddr_mem_t    mem;
    } haddr_t;

    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        hsize_byte = 3'b000,
        hsize_half = 3'b001,
        hsize_word = 3'b010
    } hsize_t;

    typedef struct packed {
        haddr_t  haddr;
        htrans_t htrans;
        hsize_t  hsize;
        logic    hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [hdata_width-1:0] hrdata;
        logic                   hreadyout;
        logic                   hresp;
    } ahb_rsp_t;

endpackage
